// ==== verilog/maze.hex ====
// one line per maze row, row 0 first, 32 wall nibbles with column 31 leftmost
// nibble bits from msb are up right down left
C889C889C889C889C889C889C809C889
60222022202220222022202220222023
C089C089C089C089C089C089C089C089
40014001400140014001400140014001
40000000000000000000000000000001
60236023602360236023602360236023
C089C089C089C089C089C089C089C089
00000000000000000000000000000001
40014001400140014001400140014001
60236023602360236023602360236023
C0888088808880888088808880888089
40014001400140014001400140014001
40014001400140014001400140014001
60222022202220222022202220222023
C089C089C089C089C089C089C089C089
40014001400140014001400140014001
40000000000000000000000000000001
60236023602360236023602360236023
C089C089C089C089C089C089C089C089
40000000000000000000000000000000
40014001400140014001400140014001
60236023602360236023602360236023
C0888088808880888088808880888089
62236223622362236223602362236223

// ==== all.f ====
verilog/maze_pkg.sv
verilog/key_pkg.sv
verilog/key_decoder.sv
verilog/maze_rom.sv
verilog/player_mover.sv
verilog/maze_game.sv
verification/maze_game_checker.sv
verification/maze_game_tb.sv

// ==== Makefile ====
TOP := maze_game_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
		--top-module $(TOP) -f all.f -o maze_sim
	out="$$(./obj_dir/maze_sim)"; echo "$$out"; echo "$$out" | grep -q "Test passed"

clean:
	rm -rf obj_dir

// ==== verification/maze_game_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module maze_game_tb
    import maze_pkg::*;
    import key_pkg::*;
();

    localparam int RESET_CYCLES = 5;
    localparam int IDLE_CYCLES  = 300;
    localparam int MOVE_TARGET  = 80;
    localparam int WAIT_LIMIT   = 3000;    // cycles per wait
    localparam int WALK_SEGS    = 150;
    localparam int SEG_CYCLES   = 24;

    logic                  clk;
    logic                  rst;
    logic                  key_valid;
    logic [KEY_CODE_W-1:0] last_change;
    logic [KEY_VEC_W-1:0]  key_down;
    walls_t                locate;
    coord_t                row;
    coord_t                column;
    logic                  move;
    logic [2:0]            test_id;
    logic                  test_end;
    logic                  timed_out;
    int                    error_count;
    int                    step_count;
    int                    block_count;

    always #10 clk = ~clk;     // 20 ns period

    maze_game dut0 (
        .clk         (clk),
        .rst         (rst),
        .key_valid   (key_valid),
        .last_change (last_change),
        .key_down    (key_down),
        .locate      (locate),
        .row         (row),
        .column      (column),
        .move        (move)
    );

    maze_game_checker checker0 (
        .clk         (clk),
        .rst         (rst),
        .key_valid   (key_valid),
        .last_change (last_change),
        .key_down    (key_down),
        .locate      (locate),
        .row         (row),
        .column      (column),
        .move        (move),
        .test_id     (test_id),
        .test_end    (test_end),
        .error_count (error_count),
        .step_count  (step_count),
        .block_count (block_count)
    );

    ////////////////////
    // stimulus helpers

    function automatic logic [KEY_CODE_W-1:0] random_arrow();
        case ($urandom % 4)
            0:       return KEY_UP;
            1:       return KEY_RIGHT;
            2:       return KEY_DOWN;
            default: return KEY_LEFT;
        endcase
    endfunction

    function automatic logic [KEY_CODE_W-1:0] random_other();
        logic [KEY_CODE_W-1:0] code;

        code = KEY_CODE_W'($urandom);
        if (code inside {KEY_UP, KEY_RIGHT, KEY_DOWN, KEY_LEFT})
        begin
            code[KEY_CODE_W-1] = 1'b1;    // extended codes are never arrows
        end
        return code;
    endfunction

    task automatic drive_keys(input logic valid, input logic [KEY_CODE_W-1:0] code,
                              input logic held);
        logic [KEY_VEC_W-1:0] held_keys;
        int                   i;

        for (i = 0; i < KEY_VEC_W / 32; i++)
        begin
            held_keys[i * 32 +: 32] = $urandom;    // noise on other keys
        end
        held_keys[code] = held;
        @(posedge clk);
        key_valid   <= valid;
        last_change <= code;
        key_down    <= held_keys;
    endtask

    task automatic close_test();
        @(posedge clk);
        key_valid <= 1'b0;
        test_end  <= 1'b1;
        @(posedge clk);
        test_end  <= 1'b0;
        test_id   <= test_id + 3'd1;
    endtask

    ////////////////////
    // tests

    task automatic press_non_moves();
        int n;

        for (n = 0; n < IDLE_CYCLES; n++)
        begin
            case ($urandom % 3)
                0:       drive_keys(1'b0, random_arrow(), 1'b1);    // strobe low
                1:       drive_keys(1'b1, random_arrow(), 1'b0);    // key released
                default: drive_keys(1'b1, random_other(), 1'b1);
            endcase
        end
        close_test();
    endtask

    // hold arrows until enough open or blocked moves are seen
    task automatic push_arrows(input logic want_steps);
        int start;
        int moved;
        int n;

        start = want_steps ? step_count : block_count;
        moved = 0;
        n     = 0;
        while (moved < MOVE_TARGET && n < WAIT_LIMIT)
        begin
            drive_keys(1'b1, random_arrow(), 1'b1);
            n++;
            moved = (want_steps ? step_count : block_count) - start;
        end
        if (moved < MOVE_TARGET)
        begin
            timed_out = 1'b1;
            $display("timeout: only %0d of %0d %s moves after %0d cycles", moved,
                     MOVE_TARGET, want_steps ? "open" : "blocked", WAIT_LIMIT);
        end
        close_test();
    endtask

    task automatic wander_to_edges();
        logic [KEY_CODE_W-1:0] heading;
        int                    s;
        int                    n;

        for (s = 0; s < WALK_SEGS; s++)
        begin
            heading = random_arrow();    // push one way for a while
            for (n = 0; n < SEG_CYCLES; n++)
            begin
                case ($urandom % 8)
                    0:       drive_keys(1'b1, random_arrow(), 1'b1);
                    1:       drive_keys(1'b1, random_other(), 1'($urandom));
                    2:       drive_keys(1'($urandom), heading, 1'b1);
                    default: drive_keys(1'b1, heading, 1'b1);
                endcase
            end
        end
        close_test();
    endtask

    ////////////////////
    // main sequence

    initial
    begin
        void'($urandom(32'ha022));
        clk         = 1'b0;
        rst         = 1'b1;
        key_valid   = 1'b0;
        last_change = '0;
        key_down    = '0;
        test_id     = '0;
        test_end    = 1'b0;
        timed_out   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        repeat (4) drive_keys(1'b0, random_arrow(), 1'b1);    // position must stay at 0,0
        close_test();
        press_non_moves();
        push_arrows(1'b1);
        if (!timed_out)
        begin
            push_arrows(1'b0);
        end
        if (!timed_out)
        begin
            wander_to_edges();
        end

        $display("tests %0d, errors %0d, open steps %0d, blocked %0d",
                 test_id, error_count, step_count, block_count);
        if (error_count == 0 && !timed_out)
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/maze_game_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module maze_game_checker
    import maze_pkg::*;
    import key_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  key_valid,
    input  logic [KEY_CODE_W-1:0] last_change,
    input  logic [KEY_VEC_W-1:0]  key_down,
    input  walls_t                locate,
    input  coord_t                row,
    input  coord_t                column,
    input  logic                  move,
    input  logic [2:0]            test_id,
    input  logic                  test_end,
    output int                    error_count,
    output int                    step_count,
    output int                    block_count
);

    localparam int RESET_TIMEOUT = 50;     // cycles

    logic [MAP_ROW_W-1:0] ref_map [MAZE_ROWS];
    int                   test_checks;
    int                   test_errors;

    function automatic walls_t cell_walls(input int r, input int c);
        if (r < 0 || r >= MAZE_ROWS || c < 0 || c >= MAZE_COLS)
        begin
            return 4'hF;    // off the map
        end
        return ref_map[r][c * WALL_W +: WALL_W];
    endfunction

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd0:    return "reset_state";
            3'd1:    return "non_moves";
            3'd2:    return "open_steps";
            3'd3:    return "blocked_steps";
            default: return "edge_walk";
        endcase
    endfunction

    task automatic compare_value(input string what, input int expected, input int actual);
        test_checks++;
        if (expected != actual)
        begin
            test_errors++;
            error_count++;
            $display("error %s %s: expected %0d, actual %0d",
                     test_name(test_id), what, expected, actual);
        end
    endtask

    ////////////////////
    // reference model sampled mid cycle

    initial
    begin : watch
        int     waited;
        int     model_row;
        int     model_col;
        int     next_row;
        int     next_col;
        int     wall_bit;
        logic   exp_move;
        walls_t here;

        error_count = 0;
        step_count  = 0;
        block_count = 0;
        test_checks = 0;
        test_errors = 0;
        model_row   = 0;
        model_col   = 0;
        $readmemh(MAZE_FILE, ref_map);

        waited = 0;
        while (rst !== 1'b0 && waited < RESET_TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        if (rst !== 1'b0)
        begin
            error_count++;
            $display("timeout: reset still asserted after %0d cycles", waited);
        end

        forever
        begin
            @(negedge clk);
            if (rst !== 1'b0)
            begin
                model_row = 0;
                model_col = 0;
            end
            else
            begin
                here = cell_walls(model_row, model_col);
                compare_value("row", model_row, int'(row));
                compare_value("column", model_col, int'(column));
                compare_value("locate", int'(cell_walls(int'(row), int'(column))),
                              int'(locate));
                compare_value("inside grid", 1, int'(row < MAZE_ROWS));

                case (last_change)
                    KEY_UP:    wall_bit = WALL_UP;
                    KEY_RIGHT: wall_bit = WALL_RIGHT;
                    KEY_DOWN:  wall_bit = WALL_DOWN;
                    KEY_LEFT:  wall_bit = WALL_LEFT;
                    default:   wall_bit = -1;     // not a movement key
                endcase
                exp_move = (wall_bit >= 0) && key_valid && key_down[last_change];
                compare_value("move", int'(exp_move), int'(move));

                next_row = model_row + int'(wall_bit == WALL_DOWN) - int'(wall_bit == WALL_UP);
                next_col = model_col + int'(wall_bit == WALL_RIGHT) - int'(wall_bit == WALL_LEFT);
                if (exp_move)
                begin
                    if (!here[wall_bit] && next_row >= 0 && next_row < MAZE_ROWS
                        && next_col >= 0 && next_col < MAZE_COLS)
                    begin
                        model_row = next_row;
                        model_col = next_col;
                        step_count++;
                    end
                    else
                    begin
                        block_count++;    // wall or grid edge
                    end
                end

                if (test_end)
                begin
                    $display("test %s: %0d checks, %0d errors",
                             test_name(test_id), test_checks, test_errors);
                    test_checks = 0;
                    test_errors = 0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/maze_game.sv ====
`timescale 1ns/100ps
`default_nettype none

module maze_game
    import maze_pkg::*;
    import key_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  key_valid,
    input  logic [KEY_CODE_W-1:0] last_change,
    input  logic [KEY_VEC_W-1:0]  key_down,
    output walls_t                locate,
    output coord_t                row,
    output coord_t                column,
    output logic                  move
);

    dir_e dir;      // decoder to mover

    ////////////////////
    // keyboard decode

    key_decoder u_key_decoder (
        .key_valid   (key_valid),
        .last_change (last_change),
        .key_down    (key_down),
        .move        (move),
        .dir         (dir)
    );

    ////////////////////
    // wall map

    // walls of the current cell, also fed back to the mover
    maze_rom u_maze_rom (
        .row    (row),
        .column (column),
        .walls  (locate)
    );

    ////////////////////
    // player position

    player_mover u_player_mover (
        .clk    (clk),
        .rst    (rst),
        .move   (move),
        .dir    (dir),
        .walls  (locate),
        .row    (row),
        .column (column)
    );

endmodule

`default_nettype wire

// ==== verilog/player_mover.sv ====
`timescale 1ns/100ps
`default_nettype none

module player_mover
    import maze_pkg::*;
    import key_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   move,
    input  dir_e   dir,
    input  walls_t walls,
    output coord_t row,
    output coord_t column
);

    coord_t nb_row;         // neighbor cell in direction dir
    coord_t nb_column;
    logic   wall_hit;       // wall on that side of the current cell
    logic   in_grid;        // neighbor stays on the board
    logic   step_ok;
    coord_t next_row;
    coord_t next_column;

    ////////////////////
    // neighbor and checks

    always_comb
    begin
        nb_row    = row;
        nb_column = column;
        wall_hit  = 1'b1;
        in_grid   = 1'b0;
        case (dir)
            DIR_UP:
            begin
                nb_row   = row - 1'b1;
                wall_hit = walls[WALL_UP];
                in_grid  = (row != '0);                             // top edge
            end
            DIR_RIGHT:
            begin
                nb_column = column + 1'b1;
                wall_hit  = walls[WALL_RIGHT];
                in_grid   = (column < COORD_W'(MAZE_COLS - 1));     // right edge
            end
            DIR_DOWN:
            begin
                nb_row   = row + 1'b1;
                wall_hit = walls[WALL_DOWN];
                in_grid  = (row < COORD_W'(MAZE_ROWS - 1));         // bottom edge
            end
            DIR_LEFT:
            begin
                nb_column = column - 1'b1;
                wall_hit  = walls[WALL_LEFT];
                in_grid   = (column != '0);                         // left edge
            end
        endcase
    end

    // a step off the board is treated like a wall
    assign step_ok = move & ~wall_hit & in_grid;

    assign next_row    = step_ok ? nb_row    : row;
    assign next_column = step_ok ? nb_column : column;

    ////////////////////
    // position registers

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row    <= '0;   // start in the top left cell
            column <= '0;
        end
        else
        begin
            row    <= next_row;
            column <= next_column;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/maze_rom.sv ====
`timescale 1ns/100ps
`default_nettype none

module maze_rom
    import maze_pkg::*;
(
    input  coord_t row,
    input  coord_t column,
    output walls_t walls
);

    logic [MAP_ROW_W-1:0] map_mem [MAZE_ROWS];

    logic                 row_ok;       // row inside the map
    logic [MAP_ROW_W-1:0] map_row;      // selected maze row

    ////////////////////
    // map load

    // one 128-bit word per maze row from row 0
    initial
    begin
        $readmemh(MAZE_FILE, map_mem);
    end

    ////////////////////
    // cell lookup

    assign row_ok = (row < COORD_W'(MAZE_ROWS));

    // rows past the bottom read as solid rock
    always_comb
    begin
        map_row = '1;
        if (row_ok)
        begin
            map_row = map_mem[row];
        end
    end

    // column 0 sits in the low nibble
    assign walls = map_row[column * WALL_W +: WALL_W];

endmodule

`default_nettype wire

// ==== verilog/key_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module key_decoder
    import key_pkg::*;
(
    input  logic                  key_valid,
    input  logic [KEY_CODE_W-1:0] last_change,
    input  logic [KEY_VEC_W-1:0]  key_down,
    output logic                  move,
    output dir_e                  dir
);

    logic is_arrow;     // last_change is a movement key
    logic key_held;     // that key is still down
    dir_e code_dir;     // direction before masking

    ////////////////////
    // scan code lookup

    always_comb
    begin
        is_arrow = 1'b1;
        code_dir = DIR_UP;
        case (last_change)
            KEY_UP:
            begin
                code_dir = DIR_UP;
            end
            KEY_RIGHT:
            begin
                code_dir = DIR_RIGHT;
            end
            KEY_DOWN:
            begin
                code_dir = DIR_DOWN;
            end
            KEY_LEFT:
            begin
                code_dir = DIR_LEFT;
            end
            default:
            begin
                is_arrow = 1'b0;    // any other key is ignored
            end
        endcase
    end

    ////////////////////
    // move strobe

    assign key_held = key_down[last_change];
    assign move     = key_valid & key_held & is_arrow;

    // idle direction is up
    assign dir = move ? code_dir : DIR_UP;

endmodule

`default_nettype wire

// ==== verilog/key_pkg.sv ====
`default_nettype none

package key_pkg;

    ////////////////////
    // keyboard state widths

    localparam int KEY_CODE_W = 9;      // scan code incl. extended bit
    localparam int KEY_VEC_W  = 512;    // one bit per scan code
    localparam int DIR_W      = 2;

    ////////////////////
    // movement keys

    typedef enum logic [KEY_CODE_W-1:0] {
        KEY_UP    = 9'h1D,
        KEY_RIGHT = 9'h23,
        KEY_DOWN  = 9'h1B,
        KEY_LEFT  = 9'h1C
    } scan_code_e;

    // order follows the wall nibble, top bit first
    typedef enum logic [DIR_W-1:0] {
        DIR_UP    = 2'd0,
        DIR_RIGHT = 2'd1,
        DIR_DOWN  = 2'd2,
        DIR_LEFT  = 2'd3
    } dir_e;

endpackage

`default_nettype wire

// ==== verilog/maze_pkg.sv ====
`default_nettype none

package maze_pkg;

    ////////////////////
    // grid size

    localparam int MAZE_COLS = 32;
    localparam int MAZE_ROWS = 24;
    localparam int COORD_W   = 5;    // enough for 0..31

    ////////////////////
    // cell walls

    localparam int WALL_W = 4;       // one nibble per cell

    // bit positions inside a wall nibble
    localparam int WALL_UP    = 3;
    localparam int WALL_RIGHT = 2;
    localparam int WALL_DOWN  = 1;
    localparam int WALL_LEFT  = 0;

    // one full maze row, column 31 in the top nibble
    localparam int MAP_ROW_W = MAZE_COLS * WALL_W;

    typedef logic [COORD_W-1:0] coord_t;
    typedef logic [WALL_W-1:0]  walls_t;

    ////////////////////
    // map data

    localparam string MAZE_FILE = "verilog/maze.hex";   // relative to project root

endpackage

`default_nettype wire
